//--- design/fpu_macros.svh
// format widths, exponent bias and limits for the bfloat16 unit
// canonical quiet NaN
`ifndef FPU_MACROS_SVH
`define FPU_MACROS_SVH

// word layout: sign, exponent, fraction
`define FPU_WIDTH    16
`define FPU_EXP_W    8
`define FPU_FRAC_W   7

// exponent encoding
`define FPU_BIAS     127
`define FPU_EXP_MAX  255

// guard, round and sticky below the fraction
`define FPU_GRS_W    3

`define FPU_QNAN     16'h7fc0

`endif

//--- design/fpu_format_pkg.sv
// number-format types for the bfloat16 datapath
// word, exponent and mantissa vectors plus the classified operand
`include "fpu_macros.svh"

package fpu_format_pkg;

	// raw word and its fields
	typedef logic [`FPU_WIDTH-1:0] fp_word_t;
	typedef logic [`FPU_EXP_W-1:0] fp_exp_t;

	// hidden bit on top of the fraction
	typedef logic [`FPU_FRAC_W:0] fp_mant_t;

	// working exponent, one carry bit and one sign bit on top
	typedef logic [`FPU_EXP_W+1:0] fp_wexp_t;

	// carry, hidden, fraction, guard/round/sticky
	typedef logic [`FPU_FRAC_W+`FPU_GRS_W+1:0] fp_wmant_t;

	// operand after split and classification
	typedef struct packed
	{
		logic     sign;
		fp_exp_t  exp;
		fp_mant_t mant;
		logic     is_zero;
		logic     is_inf;
		logic     is_nan;
	} fp_operand_t;

endpackage

//--- design/fpu_ctrl_pkg.sv
// operation and rounding enums
// structs passed between the three pipeline stages
package fpu_ctrl_pkg;

	import fpu_format_pkg::*;

	typedef enum logic [2:0]
	{
		FPU_ADD = 3'd0,
		FPU_SUB = 3'd1,
		FPU_EQ  = 3'd2,
		FPU_LT  = 3'd3,
		FPU_LE  = 3'd4
	} fpu_op_t;

	typedef enum logic
	{
		RND_NEAREST = 1'b0,
		RND_TRUNC   = 1'b1
	} fpu_rnd_t;

	// request as seen on the top-level port
	typedef struct packed
	{
		fpu_op_t  op;
		fpu_rnd_t rnd;
		fp_word_t op1;
		fp_word_t op2;
	} fpu_req_t;

	// unpack -> execute
	typedef struct packed
	{
		fpu_op_t     op;
		fpu_rnd_t    rnd;
		fp_operand_t a;
		fp_operand_t b;
	} fpu_unp_t;

	// execute -> round
	typedef struct packed
	{
		logic      is_cmp;
		logic      cmp_bit;
		fpu_rnd_t  rnd;
		logic      sign;
		fp_wexp_t  exp;
		fp_wmant_t mant;
		// result already known, skips rounding
		logic      special;
		fp_word_t  special_word;
	} fpu_exe_t;

endpackage

//--- design/fpu_unpack.sv
// first pipeline stage
// splits both operands and classifies them as zero, infinity or NaN
`include "fpu_macros.svh"

module fpu_unpack
	import fpu_format_pkg::*, fpu_ctrl_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     in_valid_i,
	output logic     in_ready_o,
	input  fpu_req_t req_i,
	output logic     out_valid_o,
	input  logic     out_ready_i,
	output fpu_unp_t unp_o
);

	fp_operand_t op_a;
	fp_operand_t op_b;

	// split one word, subnormals read as zero
	function automatic fp_operand_t classify(input fp_word_t w);
		fp_operand_t o;
		fp_exp_t e;
		logic [`FPU_FRAC_W-1:0] f;
		e = w[`FPU_WIDTH-2 -: `FPU_EXP_W];
		f = w[`FPU_FRAC_W-1:0];
		o.sign    = w[`FPU_WIDTH-1];
		o.exp     = e;
		o.is_zero = (e == '0);
		o.is_inf  = (e == fp_exp_t'(`FPU_EXP_MAX)) && (f == '0);
		o.is_nan  = (e == fp_exp_t'(`FPU_EXP_MAX)) && (f != '0);
		// hidden bit only for normal numbers
		o.mant    = o.is_zero ? '0 : {1'b1, f};
		return o;
	endfunction

	assign op_a = classify(req_i.op1);
	assign op_b = classify(req_i.op2);

	////////////////////////////////////////////////////////////////////////////
	// stage register

	// empty, or the next stage takes our item this cycle
	assign in_ready_o = !out_valid_o || out_ready_i;

	always_ff @(posedge clk)
	begin
		if (rst)
			out_valid_o <= 1'b0;
		else if (in_ready_o)
			out_valid_o <= in_valid_i;
	end

	always_ff @(posedge clk)
	begin
		if (in_valid_i && in_ready_o)
			unp_o <= '{op: req_i.op, rnd: req_i.rnd, a: op_a, b: op_b};
	end

endmodule

//--- design/fpu_addsub.sv
// add/subtract datapath
// alignment with sticky, signed mantissa add, leading-one normalization
`include "fpu_macros.svh"

module fpu_addsub
	import fpu_format_pkg::*;
(
	input  fp_operand_t a_i,
	input  fp_operand_t b_i,
	input  logic        subtract_i,
	output logic        sign_o,
	output fp_wexp_t    exp_o,
	output fp_wmant_t   mant_o,
	output logic        special_o,
	output fp_word_t    special_word_o
);

	// index of the hidden bit in the working mantissa
	localparam int TOP = `FPU_FRAC_W + `FPU_GRS_W;

	fp_operand_t b_eff;
	fp_operand_t big_op;
	fp_operand_t small_op;
	fp_exp_t     exp_diff;
	logic [TOP:0] sm_full;
	logic [TOP:0] sm_shift;
	logic         sticky;
	logic         eff_sub;
	fp_wmant_t    big_m;
	fp_wmant_t    sm_m;
	fp_wmant_t    sum;
	logic [3:0]   lz;
	logic         found;

	always_comb
	begin
		b_eff = b_i;
		b_eff.sign = b_i.sign ^ subtract_i;

		// larger magnitude goes first
		if ({a_i.exp, a_i.mant} >= {b_eff.exp, b_eff.mant})
		begin
			big_op   = a_i;
			small_op = b_eff;
		end
		else
		begin
			big_op   = b_eff;
			small_op = a_i;
		end
		exp_diff = big_op.exp - small_op.exp;

		// align, bits shifted out fold into sticky
		sm_full  = {small_op.mant, {`FPU_GRS_W{1'b0}}};
		sm_shift = sm_full >> exp_diff;
		sticky   = |(sm_full & ~({(TOP+1){1'b1}} << exp_diff));
		sm_shift[0] = sm_shift[0] | sticky;

		eff_sub = big_op.sign ^ small_op.sign;
		big_m   = {1'b0, big_op.mant, {`FPU_GRS_W{1'b0}}};
		sm_m    = {1'b0, sm_shift};
		sum     = eff_sub ? (big_m - sm_m) : (big_m + sm_m);

		// leading one below the carry bit
		lz    = '0;
		found = 1'b0;
		for (int i = TOP; i >= 0; i--)
		begin
			if (!found && sum[i])
			begin
				lz    = 4'(TOP - i);
				found = 1'b1;
			end
		end

		sign_o = big_op.sign;
		if (sum[TOP+1])
		begin
			mant_o = {1'b0, sum[TOP+1:2], sum[1] | sum[0]};
			exp_o  = fp_wexp_t'(big_op.exp) + fp_wexp_t'(1);
		end
		else
		begin
			mant_o = sum << lz;
			exp_o  = fp_wexp_t'(big_op.exp) - fp_wexp_t'(lz);
		end

		// NaN and infinity cases, then exact zero
		special_o      = 1'b1;
		special_word_o = '0;
		if (a_i.is_nan || b_eff.is_nan)
			special_word_o = `FPU_QNAN;
		else if (a_i.is_inf && b_eff.is_inf && (a_i.sign != b_eff.sign))
			special_word_o = `FPU_QNAN;
		else if (a_i.is_inf)
			special_word_o = {a_i.sign, fp_exp_t'(`FPU_EXP_MAX), {`FPU_FRAC_W{1'b0}}};
		else if (b_eff.is_inf)
			special_word_o = {b_eff.sign, fp_exp_t'(`FPU_EXP_MAX), {`FPU_FRAC_W{1'b0}}};
		else if (sum == '0)
			// -0 only when both inputs are -0
			special_word_o = {a_i.sign & b_eff.sign, {(`FPU_WIDTH-1){1'b0}}};
		else
			special_o = 1'b0;
	end

endmodule

//--- design/fpu_cmp.sv
// ordered comparison for EQ, LT and LE
// +0 equals -0, any NaN gives false
module fpu_cmp
	import fpu_format_pkg::*, fpu_ctrl_pkg::*;
(
	input  fp_operand_t a_i,
	input  fp_operand_t b_i,
	input  fpu_op_t     op_i,
	output logic        cmp_o
);

	logic both_zero;
	logic mag_lt;
	logic mag_gt;
	logic eq;
	logic lt;

	assign both_zero = a_i.is_zero && b_i.is_zero;
	assign mag_lt    = {a_i.exp, a_i.mant} < {b_i.exp, b_i.mant};
	assign mag_gt    = {b_i.exp, b_i.mant} < {a_i.exp, a_i.mant};

	assign eq = both_zero || ({a_i.sign, a_i.exp, a_i.mant} == {b_i.sign, b_i.exp, b_i.mant});

	// sign first, then magnitude, reversed for negatives
	assign lt = both_zero ? 1'b0 :
		(a_i.sign != b_i.sign) ? a_i.sign :
		a_i.sign ? mag_gt : mag_lt;

	always_comb
	begin
		cmp_o = 1'b0;
		if (!a_i.is_nan && !b_i.is_nan)
		begin
			case (op_i)
				FPU_EQ:  cmp_o = eq;
				FPU_LT:  cmp_o = lt;
				FPU_LE:  cmp_o = lt || eq;
				default: cmp_o = 1'b0;
			endcase
		end
	end

endmodule

//--- design/fpu_execute.sv
// second pipeline stage
// add/sub and compare datapaths with the stage register
module fpu_execute
	import fpu_format_pkg::*, fpu_ctrl_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     in_valid_i,
	output logic     in_ready_o,
	input  fpu_unp_t unp_i,
	output logic     out_valid_o,
	input  logic     out_ready_i,
	output fpu_exe_t exe_o
);

	logic      as_sign;
	fp_wexp_t  as_exp;
	fp_wmant_t as_mant;
	logic      as_special;
	fp_word_t  as_special_word;
	logic      cmp_bit;
	logic      is_cmp;
	fpu_exe_t  exe_d;

	fpu_addsub u_addsub (
		.a_i            (unp_i.a),
		.b_i            (unp_i.b),
		.subtract_i     (unp_i.op == FPU_SUB),
		.sign_o         (as_sign),
		.exp_o          (as_exp),
		.mant_o         (as_mant),
		.special_o      (as_special),
		.special_word_o (as_special_word)
	);

	fpu_cmp u_cmp (
		.a_i   (unp_i.a),
		.b_i   (unp_i.b),
		.op_i  (unp_i.op),
		.cmp_o (cmp_bit)
	);

	assign is_cmp = unp_i.op inside {FPU_EQ, FPU_LT, FPU_LE};

	// compares bypass rounding entirely
	assign exe_d = '{is_cmp: is_cmp, cmp_bit: cmp_bit, rnd: unp_i.rnd,
		sign: as_sign, exp: as_exp, mant: as_mant,
		special: !is_cmp && as_special, special_word: as_special_word};

	////////////////////////////////////////////////////////////////////////////
	// stage register

	assign in_ready_o = !out_valid_o || out_ready_i;

	always_ff @(posedge clk)
	begin
		if (rst)
			out_valid_o <= 1'b0;
		else if (in_ready_o)
			out_valid_o <= in_valid_i;
	end

	always_ff @(posedge clk)
	begin
		if (in_valid_i && in_ready_o)
			exe_o <= exe_d;
	end

endmodule

//--- design/fpu_round.sv
// third pipeline stage
// rounding, overflow and underflow, result select and output register
`include "fpu_macros.svh"

module fpu_round
	import fpu_format_pkg::*, fpu_ctrl_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     in_valid_i,
	output logic     in_ready_o,
	input  fpu_exe_t exe_i,
	output logic     out_valid_o,
	input  logic     out_ready_i,
	output fp_word_t res_o
);

	// largest finite biased exponent is twice the bias
	localparam fp_exp_t EXP_MAXFIN = fp_exp_t'(2 * `FPU_BIAS);
	localparam int      TOP        = `FPU_FRAC_W + `FPU_GRS_W;

	logic                  round_up;
	logic [`FPU_FRAC_W+1:0] rounded;
	fp_wexp_t              exp_r;
	logic                  overflow;
	logic                  underflow;
	fp_word_t              word;

	// nearest even: guard and (round | sticky | lsb)
	assign round_up = (exe_i.rnd == RND_NEAREST) && exe_i.mant[`FPU_GRS_W-1]
		&& (exe_i.mant[1] || exe_i.mant[0] || exe_i.mant[`FPU_GRS_W]);

	assign rounded = {1'b0, exe_i.mant[TOP -: `FPU_FRAC_W+1]}
		+ {{(`FPU_FRAC_W+1){1'b0}}, round_up};

	// carry out of rounding bumps the exponent, fraction bits are zero then
	assign exp_r = exe_i.exp + fp_wexp_t'(rounded[`FPU_FRAC_W+1]);

	assign overflow  = !exp_r[`FPU_EXP_W+1] && (exp_r >= fp_wexp_t'(`FPU_EXP_MAX));
	assign underflow = exp_r[`FPU_EXP_W+1] || (exp_r == '0);

	always_comb
	begin
		if (exe_i.is_cmp)
			word = fp_word_t'(exe_i.cmp_bit);
		else if (exe_i.special)
			word = exe_i.special_word;
		else if (overflow && (exe_i.rnd == RND_NEAREST))
			word = {exe_i.sign, fp_exp_t'(`FPU_EXP_MAX), {`FPU_FRAC_W{1'b0}}};
		else if (overflow)
			word = {exe_i.sign, EXP_MAXFIN, {`FPU_FRAC_W{1'b1}}};
		else if (underflow)
			word = {exe_i.sign, {(`FPU_WIDTH-1){1'b0}}};
		else
			word = {exe_i.sign, exp_r[`FPU_EXP_W-1:0], rounded[`FPU_FRAC_W-1:0]};
	end

	////////////////////////////////////////////////////////////////////////////
	// output register

	assign in_ready_o = !out_valid_o || out_ready_i;

	always_ff @(posedge clk)
	begin
		if (rst)
			out_valid_o <= 1'b0;
		else if (in_ready_o)
			out_valid_o <= in_valid_i;
	end

	always_ff @(posedge clk)
	begin
		if (in_valid_i && in_ready_o)
			res_o <= word;
	end

endmodule

//--- design/fpu_top.sv
// bfloat16 FPU top level
// unpack, execute and round stages chained by valid/ready
module fpu_top
	import fpu_format_pkg::*, fpu_ctrl_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     req_valid_i,
	output logic     req_ready_o,
	input  fpu_req_t req_i,
	output logic     res_valid_o,
	input  logic     res_ready_i,
	output fp_word_t res_o
);

	logic     unp_valid;
	logic     unp_ready;
	fpu_unp_t unp;
	logic     exe_valid;
	logic     exe_ready;
	fpu_exe_t exe;

	fpu_unpack u_unpack (
		.clk         (clk),
		.rst         (rst),
		.in_valid_i  (req_valid_i),
		.in_ready_o  (req_ready_o),
		.req_i       (req_i),
		.out_valid_o (unp_valid),
		.out_ready_i (unp_ready),
		.unp_o       (unp)
	);

	fpu_execute u_execute (
		.clk         (clk),
		.rst         (rst),
		.in_valid_i  (unp_valid),
		.in_ready_o  (unp_ready),
		.unp_i       (unp),
		.out_valid_o (exe_valid),
		.out_ready_i (exe_ready),
		.exe_o       (exe)
	);

	fpu_round u_round (
		.clk         (clk),
		.rst         (rst),
		.in_valid_i  (exe_valid),
		.in_ready_o  (exe_ready),
		.exe_i       (exe),
		.out_valid_o (res_valid_o),
		.out_ready_i (res_ready_i),
		.res_o       (res_o)
	);

endmodule

//--- bench/fpu_checker.sv
// result checker for the FPU testbench
// compares each result with the expected column, checks steady-flow latency
module fpu_checker
	import fpu_format_pkg::*;
#(
	parameter int MAX_LINES = 64,
	parameter int STEADY_N  = 8
)
(
	input  logic     clk,
	input  logic     rst,
	input  logic     req_valid_i,
	input  logic     req_ready_i,
	input  logic     res_valid_i,
	input  logic     res_ready_i,
	input  fp_word_t res_i,
	output int       rx_count_o,
	output int       pass_count_o,
	output int       fail_count_o
);

	localparam int FIELDS = 5;

	logic [15:0] stim [0:MAX_LINES*FIELDS-1];
	int n_lines;
	int cycle;
	int idx;
	int passes;
	int fails;
	int last_res;
	int accept_q[$];

	initial
	begin
		for (int i = 0; i < MAX_LINES*FIELDS; i++)
			stim[i] = 16'hf000 | 16'(i);
		$readmemh("bench/fpu_stim.txt", stim);
		n_lines = 0;
		while (n_lines < MAX_LINES && stim[n_lines*FIELDS][15:12] != 4'hf)
			n_lines++;
	end

	////////////////////////////////////////////////////////////////////////////
	// per-result check

	task automatic check_result();
		int base;
		int acc;
		logic ok;
		base = idx * FIELDS;
		if (idx >= n_lines)
		begin
			$display("unexpected result %h at time %0t, all %0d tests were already answered",
				res_i, $time, n_lines);
			fails++;
			return;
		end
		ok = 1'b1;
		if (res_i !== stim[base+4])
		begin
			$display("Error at time %0t: test %0d expected %h, got %h",
				$time, idx, stim[base+4], res_i);
			ok = 1'b0;
		end
		acc = -1;
		if (accept_q.size() > 0)
			acc = accept_q.pop_front();
		// ready stayed high for these, so the latency is exact
		if (idx < STEADY_N && cycle - acc != 3)
		begin
			$display("test %0d came out %0d cycles after it was accepted instead of 3",
				idx, cycle - acc);
			ok = 1'b0;
		end
		if (idx > 0 && idx < STEADY_N && cycle - last_res != 1)
		begin
			$display("test %0d did not follow the previous result on the next cycle", idx);
			ok = 1'b0;
		end
		$display("test %0d: op %0d rnd %0d %h %h -> %h %s", idx, stim[base][2:0],
			stim[base+1][0], stim[base+2], stim[base+3], res_i, ok ? "ok" : "wrong");
		if (ok)
			passes++;
		else
			fails++;
		last_res = cycle;
		idx++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// handshake monitor

	always @(posedge clk)
	begin
		if (rst)
		begin
			cycle    = 0;
			idx      = 0;
			passes   = 0;
			fails    = 0;
			last_res = 0;
			accept_q.delete();
		end
		else
		begin
			cycle++;
			if (req_valid_i && req_ready_i)
				accept_q.push_back(cycle);
			if (res_valid_i && res_ready_i)
				check_result();
		end
		rx_count_o   <= idx;
		pass_count_o <= passes;
		fail_count_o <= fails;
	end

endmodule

//--- bench/fpu_tb.sv
// testbench top for the bfloat16 FPU
// clock, reset, requests from the stim file, random result back-pressure, timeout
module fpu_tb
	import fpu_format_pkg::*, fpu_ctrl_pkg::*;
();

	localparam int MAX_LINES = 64;
	localparam int FIELDS    = 5;
	// leading tests that run with res_ready_i held high
	localparam int STEADY_N  = 8;

	logic     clk;
	logic     rst;
	logic     req_valid;
	logic     req_ready;
	fpu_req_t req;
	logic     res_valid;
	logic     res_ready;
	fp_word_t res;

	logic [15:0] stim [0:MAX_LINES*FIELDS-1];
	int     n_lines;
	int     limit;
	int     cycles = 0;
	int     rx_count;
	int     pass_count;
	int     fail_count;
	integer seed;

	fpu_top uut (
		.clk         (clk),
		.rst         (rst),
		.req_valid_i (req_valid),
		.req_ready_o (req_ready),
		.req_i       (req),
		.res_valid_o (res_valid),
		.res_ready_i (res_ready),
		.res_o       (res)
	);

	fpu_checker #(
		.MAX_LINES (MAX_LINES),
		.STEADY_N  (STEADY_N)
	) u_checker (
		.clk          (clk),
		.rst          (rst),
		.req_valid_i  (req_valid),
		.req_ready_i  (req_ready),
		.res_valid_i  (res_valid),
		.res_ready_i  (res_ready),
		.res_i        (res),
		.rx_count_o   (rx_count),
		.pass_count_o (pass_count),
		.fail_count_o (fail_count)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
		cycles <= cycles + 1;

	// result back-pressure, fully open until the steady-flow tests are out
	always @(posedge clk)
	begin
		#2;
		if (rx_count < STEADY_N)
			res_ready = 1'b1;
		else
			res_ready = ($random(seed) & 3) != 0;
	end

	// one request per line, held until the DUT takes it
	task automatic drive_requests();
		int base;
		logic accepted;
		for (int i = 0; i < n_lines; i++)
		begin
			base      = i * FIELDS;
			req.op    = fpu_op_t'(stim[base][2:0]);
			req.rnd   = fpu_rnd_t'(stim[base+1][0]);
			req.op1   = stim[base+2];
			req.op2   = stim[base+3];
			req_valid = 1'b1;
			accepted  = 1'b0;
			while (!accepted)
			begin
				// ready has settled by the falling edge
				@(negedge clk);
				accepted = req_ready;
				@(posedge clk);
				#2;
			end
		end
		req_valid = 1'b0;
	endtask

	initial
	begin
		clk       = 1'b0;
		rst       = 1'b1;
		req_valid = 1'b0;
		req       = '0;
		res_ready = 1'b0;
		seed      = 32'hfea4b149;
		// unused entries carry an invalid op in the top nibble
		for (int i = 0; i < MAX_LINES*FIELDS; i++)
			stim[i] = 16'hf000 | 16'(i);
		$readmemh("bench/fpu_stim.txt", stim);
		n_lines = 0;
		while (n_lines < MAX_LINES && stim[n_lines*FIELDS][15:12] != 4'hf)
			n_lines++;
		limit = 16 + 8 * n_lines;

		repeat (16) @(posedge clk);
		#2;
		rst = 1'b0;
		fork
			drive_requests();
		join_none

		while (rx_count < n_lines && cycles < limit)
			@(posedge clk);

		if (n_lines == 0)
		begin
			$display("no stimulus lines could be read from bench/fpu_stim.txt");
			$display("TB FAILED");
		end
		else if (rx_count < n_lines)
		begin
			$display("timeout after %0d cycles, results are missing: %0d of %0d arrived",
				cycles, rx_count, n_lines);
			$display("TB FAILED");
		end
		else
		begin
			// a few idle cycles to catch a surplus result
			repeat (4) @(posedge clk);
			$display("%0d tests, %0d passed, %0d failed", n_lines, pass_count, fail_count);
			if (fail_count == 0)
				$display("TB PASSED");
			else
				$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- all.f
+incdir+design
design/fpu_format_pkg.sv
design/fpu_ctrl_pkg.sv
design/fpu_unpack.sv
design/fpu_addsub.sv
design/fpu_cmp.sv
design/fpu_execute.sv
design/fpu_round.sv
design/fpu_top.sv
bench/fpu_checker.sv
bench/fpu_tb.sv

//--- bench/fpu_stim.txt
// op rnd op1 op2 expected, one test per line, all hex
// op 0 add, 1 sub, 2 eq, 3 lt, 4 le; rnd 0 nearest even, 1 truncate
0 0 3f80 3f80 4000
0 0 3f80 4000 4040
1 0 4040 3f80 4000
1 0 3f80 3f80 0000
0 0 8000 8000 8000
2 0 3f80 3f80 0001
3 0 3f80 4000 0001
0 0 4040 bf80 4000
0 0 3f80 3b80 3f80
0 0 3f81 3b80 3f82
0 1 3f81 3b80 3f81
0 0 3f80 3bc0 3f81
0 1 3f80 3bc0 3f80
0 0 3f80 3b81 3f81
1 0 3f81 3f80 3c00
1 0 3f80 3b81 3f7f
1 1 3f80 3b81 3f7e
0 0 7f7f 7f7f 7f80
0 1 7f7f 7f7f 7f7f
0 0 ff7f ff7f ff80
1 0 0080 0081 8000
0 0 7f81 3f80 7fc0
1 0 7f80 7f80 7fc0
0 0 ff80 3f80 ff80
0 0 0001 3f80 3f80
1 0 8000 0000 8000
2 0 0000 8000 0001
4 0 8000 0000 0001
3 0 c000 bf80 0001
3 0 ff80 7f80 0001
4 0 7fc0 3f80 0000
2 0 7fc0 7fc0 0000
